// ==== sim.f ====
+incdir+sim
rtl/sprite_pkg.sv
rtl/sprite_fetch.sv
rtl/sprite_shifter.sv
rtl/sprite_collision.sv
rtl/sprite_unit.sv
sim/sprite_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with verilator, run, and decide from the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module sprite_tb \
    -Mdir "$build_dir" -o sprite_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sprite_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
    exit 0
fi
exit 1

// ==== sim/sprite_model.svh ====
`ifndef sprite_model_svh
`define sprite_model_svh

// collision state the cpu should read back
logic [7:0] m_m2m;
logic [7:0] m_m2d;
logic       m_immc;
logic       m_imbc;
// interrupt arms again only after a register clear
logic       m_trig_m2m;
logic       m_trig_m2d;
// border level at the previous stage pulse
logic       m_border_prev;

// delayed pixel of one sprite once the beam has reached xpos p
function automatic sprite_pkg::pixel_t expected_pixel(input logic [23:0] data,
                                                      input sprite_pkg::sprite_cfg_t c,
                                                      input int p);
    int j;
    int hold;
    int idx;
    j = p - pixel_delay - int'(c.x);
    hold = c.xe ? 2 : 1;
    if (!c.dma || j < 0) begin
        return 2'b00;
    end
    if (c.mmc) begin
        // bit pairs leave msb pair first, each shown for two dots
        idx = j / (2 * hold);
        if (idx >= 12) begin
            return 2'b00;
        end
        return {data[23 - 2 * idx], data[22 - 2 * idx]};
    end
    idx = j / hold;
    if (idx >= 24) begin
        return 2'b00;
    end
    // hires bit sits in the high position
    return {data[23 - idx], 1'b0};
endfunction

// one dot of collision detection on the delayed pixels
task automatic model_collide(input sprite_pkg::pixel_t [7:0] px,
                             input sprite_pkg::sprite_cfg_t [7:0] c,
                             input logic bg,
                             input logic border);
    logic [7:0] vec;
    logic [7:0] vis;
    for (int n = 0; n < 8; n++) begin
        vec[n] = px[n][1];
        vis[n] = c[n].mmc ? (px[n] != 2'b00) : px[n][1];
    end
    // overlap needs at least two sprites on bit 1
    if ($countones(vec) > 1) begin
        m_immc = m_immc | !m_trig_m2m;
        m_trig_m2m = 1'b1;
        m_m2m = m_m2m | vec;
    end
    // the pixel where the border comes on is still foreground
    if (!bg && (!border || !m_border_prev) && (vis != 8'h00)) begin
        m_imbc = m_imbc | !m_trig_m2d;
        m_trig_m2d = 1'b1;
        m_m2d = m_m2d | vis;
    end
    m_border_prev = border;
endtask

task automatic model_clear(input sprite_pkg::coll_clr_t clr_in);
    if (clr_in.m2m_clr) begin
        m_m2m = 8'h00;
        m_trig_m2m = 1'b0;
    end
    if (clr_in.m2d_clr) begin
        m_m2d = 8'h00;
        m_trig_m2d = 1'b0;
    end
    if (clr_in.immc_clr) m_immc = 1'b0;
    if (clr_in.imbc_clr) m_imbc = 1'b0;
endtask

`endif

// ==== sim/sprite_tb.sv ====
`timescale 1ns/1ns

module sprite_tb;

    localparam int pixel_delay = 6;
    localparam int clk_period = 10;
    localparam int num_lines = 12;
    localparam int dot_timeout = 8;
    localparam int phi_timeout = 64;

    logic                          clk_dot4x;
    logic                          rst;
    logic                          dot_rising_0;
    logic                          clk_phi;
    logic                          dav;
    sprite_pkg::vic_cycle_e        cycle_type;
    logic [2:0]                    sprite_cnt;
    logic [11:0]                   dbi;
    logic                          aec;
    logic [8:0]                    xpos;
    sprite_pkg::sprite_cfg_t [7:0] cfg;
    logic                          stage;
    logic                          bg;
    logic                          border;
    sprite_pkg::coll_clr_t         clr;
    sprite_pkg::pixel_t [7:0]      pixel;
    sprite_pkg::coll_flags_t       flags;

    integer      seed;
    int          cyc;
    int          checks;
    int          errors;
    // contents each shifter should hold with the first byte on top
    logic [23:0] model_data [8];

    `include "sprite_model.svh"

    sprite_unit #(
        .pixel_delay (pixel_delay)
    ) UUT (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .dot_rising_0_i        (dot_rising_0),
        .clk_phi_i             (clk_phi),
        .phi_phase_start_dav_i (dav),
        .cycle_type_i          (cycle_type),
        .sprite_cnt_i          (sprite_cnt),
        .dbi_i                 (dbi),
        .aec_i                 (aec),
        .xpos_i                (xpos),
        .sprite_cfg_i          (cfg),
        .stage_i               (stage),
        .is_background_pixel_i (bg),
        .main_border_i         (border),
        .coll_clr_i            (clr),
        .sprite_pixel_o        (pixel),
        .coll_flags_o          (flags)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(clk_period / 2) clk_dot4x = !clk_dot4x;
    end

    // dot strobe every 4 clocks, stage 2 clocks later, phi flips every 8 dots
    task automatic next_cycle();
        @(negedge clk_dot4x);
        cyc++;
        dot_rising_0 = (cyc % 4 == 0);
        stage = (cyc % 4 == 2);
        if (cyc % 32 == 0) clk_phi = !clk_phi;
    endtask

    task automatic wait_dot();
        int n;
        n = 0;
        next_cycle();
        while (!dot_rising_0 && n < dot_timeout) begin
            next_cycle();
            n++;
        end
        if (!dot_rising_0) begin
            $display("timeout: no dot strobe within %0d clocks", dot_timeout);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic wait_phi_low();
        int n;
        n = 0;
        next_cycle();
        while (clk_phi && n < phi_timeout) begin
            next_cycle();
            n++;
        end
        if (clk_phi) begin
            $display("timeout: phi stayed high for %0d clocks", phi_timeout);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            // one rising edge with phi low publishes the pending flags
            next_cycle();
        end
    endtask

    function automatic string pixel_test(input sprite_pkg::sprite_cfg_t c);
        if (!c.dma) return "disabled_sprite";
        if (c.xe || c.mmc) return "expand_multicolor";
        return "fetch_shift";
    endfunction

    task automatic apply_reset();
        next_cycle();
        rst = 1'b1;
        repeat (8) next_cycle();
        rst = 1'b0;
        // reset empties every shifter
        for (int n = 0; n < 8; n++) begin
            model_data[n] = 24'h000000;
        end
        model_clear(sprite_pkg::coll_clr_t'(4'hf));
        checks++;
        if (pixel !== '0 || flags !== '0) begin
            errors++;
            $display("[ERROR] reset: expected pixels 0 flags 0, actual pixels %h flags %h",
                     pixel, flags);
        end
    endtask

    // new random sprite settings, then three s-access bytes per sprite
    task automatic start_line();
        logic [31:0] r;
        next_cycle();
        xpos = 9'h1ff;
        bg = 1'b1;
        border = 1'b0;
        m_border_prev = 1'b0;
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            // x kept low enough that every sprite drains within the line
            cfg[n].x = 9'(r[15:0] % 16'd320);
            cfg[n].xe = r[16];
            cfg[n].mmc = r[17];
            cfg[n].dma = (r[19:18] != 2'b00);
        end
        for (int n = 0; n < 8; n++) begin
            for (int b = 0; b < 3; b++) begin
                r = $random(seed);
                next_cycle();
                dav = 1'b1;
                cycle_type = (b == 0) ? sprite_pkg::vic_hs1 :
                             (b == 1) ? sprite_pkg::vic_ls2 : sprite_pkg::vic_hs3;
                sprite_cnt = 3'(n);
                dbi = r[11:0];
                aec = (r[13:12] == 2'b00);
                if (cfg[n].dma) begin
                    model_data[n] = {model_data[n][15:0], aec ? 8'hff : dbi[7:0]};
                end
                next_cycle();
                dav = 1'b0;
                // a char fetch at the dav strobe must not load anything
                next_cycle();
                dav = 1'b1;
                cycle_type = sprite_pkg::vic_char;
                dbi = r[27:16];
                next_cycle();
                dav = 1'b0;
            end
        end
        // some sprites change dma after their fetches
        // one that loses it must stay dark
        // one that gains it shows whatever its register still holds
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                cfg[n].dma = !cfg[n].dma;
            end
        end
    endtask

    task automatic sweep_line();
        logic [31:0]              r;
        int                       bstart;
        int                       bend;
        sprite_pkg::pixel_t [7:0] exp_px;
        r = $random(seed);
        bstart = int'(r[6:0]);
        bend = 150 + int'(r[15:8]);
        for (int p = 0; p <= 400; p++) begin
            wait_dot();
            xpos = 9'(p);
            // sample after the strobe edge
            next_cycle();
            for (int n = 0; n < 8; n++) begin
                exp_px[n] = expected_pixel(model_data[n], cfg[n], p);
                checks++;
                if (pixel[n] !== exp_px[n]) begin
                    errors++;
                    $display("[ERROR] %s sprite %0d xpos %0d: expected %0d, actual %0d",
                             pixel_test(cfg[n]), n, p, exp_px[n], pixel[n]);
                end
            end
            // background and border change with the stage pulse
            next_cycle();
            r = $random(seed);
            bg = r[0];
            border = (p < bstart) || (p > bend);
            model_collide(exp_px, cfg, bg, border);
        end
        bg = 1'b1;
        // enabled sprites have shifted out everything they held
        for (int n = 0; n < 8; n++) begin
            if (cfg[n].dma) begin
                model_data[n] = 24'h000000;
            end
        end
    endtask

    task automatic check_flags(input string when);
        checks += 2;
        if (flags.m2m !== m_m2m || flags.immc !== m_immc) begin
            errors++;
            $display("[ERROR] m2m_collision %s: expected %h/%b, actual %h/%b",
                     when, m_m2m, m_immc, flags.m2m, flags.immc);
        end
        if (flags.m2d !== m_m2d || flags.imbc !== m_imbc) begin
            errors++;
            $display("[ERROR] m2d_collision %s: expected %h/%b, actual %h/%b",
                     when, m_m2d, m_imbc, flags.m2d, flags.imbc);
        end
    endtask

    initial begin
        seed = 32'h3fb1_050c;
        cyc = 0;
        checks = 0;
        errors = 0;
        rst = 1'b1;
        dot_rising_0 = 1'b0;
        clk_phi = 1'b0;
        dav = 1'b0;
        cycle_type = sprite_pkg::vic_idle;
        sprite_cnt = 3'd0;
        dbi = 12'h000;
        aec = 1'b0;
        xpos = 9'h1ff;
        cfg = '0;
        stage = 1'b0;
        bg = 1'b1;
        border = 1'b0;
        clr = '0;
        apply_reset();
        for (int line = 0; line < num_lines; line++) begin
            // reset again halfway with collision state built up
            if (line == num_lines / 2) apply_reset();
            start_line();
            sweep_line();
            wait_phi_low();
            check_flags("end of line");
            next_cycle();
            clr = sprite_pkg::coll_clr_t'(4'($random(seed)));
            model_clear(clr);
            next_cycle();
            clr = '0;
            check_flags("after clear");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/sprite_unit.sv ====
`timescale 1ns/1ns

module sprite_unit #(
    parameter int pixel_delay = 6
) (
    input  logic                                                    clk_dot4x,
    input  logic                                                    rst,
    input  logic                                                    dot_rising_0_i,
    input  logic                                                    clk_phi_i,
    input  logic                                                    phi_phase_start_dav_i,
    input  sprite_pkg::vic_cycle_e                                  cycle_type_i,
    input  logic [2:0]                                              sprite_cnt_i,
    input  logic [11:0]                                             dbi_i,
    input  logic                                                    aec_i,
    input  logic [sprite_pkg::sprite_x_w-1:0]                       xpos_i,
    input  sprite_pkg::sprite_cfg_t [sprite_pkg::num_sprites-1:0]   sprite_cfg_i,
    input  logic                                                    stage_i,
    input  logic                                                    is_background_pixel_i,
    input  logic                                                    main_border_i,
    input  sprite_pkg::coll_clr_t                                   coll_clr_i,
    output sprite_pkg::pixel_t [sprite_pkg::num_sprites-1:0]        sprite_pixel_o,
    output sprite_pkg::coll_flags_t                                 coll_flags_o
);

    localparam int ns = sprite_pkg::num_sprites;

    // per-sprite config bits gathered into vectors
    logic [ns-1:0]        dma;
    logic [ns-1:0]        mmc;

    // shared s-access bus to all shifters
    sprite_pkg::fetch_t   fetch;

    always_comb begin
        for (int n = 0; n < ns; n++) begin
            dma[n] = sprite_cfg_i[n].dma;
            mmc[n] = sprite_cfg_i[n].mmc;
        end
    end

    // s-access decode, one load strobe per sprite
    sprite_fetch u_fetch (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .phi_phase_start_dav_i (phi_phase_start_dav_i),
        .cycle_type_i          (cycle_type_i),
        .sprite_cnt_i          (sprite_cnt_i),
        .dma_i                 (dma),
        .dbi_i                 (dbi_i),
        .aec_i                 (aec_i),
        .fetch_o               (fetch)
    );

    // one shifter and delay line per sprite
    for (genvar g = 0; g < ns; g++) begin : g_sprite
        sprite_shifter #(
            .pixel_delay (pixel_delay)
        ) u_shifter (
            .clk_dot4x      (clk_dot4x),
            .rst            (rst),
            .dot_rising_0_i (dot_rising_0_i),
            .cfg_i          (sprite_cfg_i[g]),
            .xpos_i         (xpos_i),
            .load_i         (fetch.load[g]),
            .load_byte_i    (fetch.data),
            .pixel_o        (sprite_pixel_o[g])
        );
    end

    // collisions look at the delayed pixels, same as the sequencer
    sprite_collision u_collision (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .clk_phi_i             (clk_phi_i),
        .stage_i               (stage_i),
        .pixel_i               (sprite_pixel_o),
        .mmc_i                 (mmc),
        .is_background_pixel_i (is_background_pixel_i),
        .main_border_i         (main_border_i),
        .coll_clr_i            (coll_clr_i),
        .coll_flags_o          (coll_flags_o)
    );

endmodule

// ==== rtl/sprite_collision.sv ====
`timescale 1ns/1ns

module sprite_collision (
    input  logic                                                    clk_dot4x,
    input  logic                                                    rst,
    input  logic                                                    clk_phi_i,
    input  logic                                                    stage_i,
    input  sprite_pkg::pixel_t [sprite_pkg::num_sprites-1:0]        pixel_i,
    input  logic [sprite_pkg::num_sprites-1:0]                      mmc_i,
    input  logic                                                    is_background_pixel_i,
    input  logic                                                    main_border_i,
    input  sprite_pkg::coll_clr_t                                   coll_clr_i,
    output sprite_pkg::coll_flags_t                                 coll_flags_o
);

    localparam int ns = sprite_pkg::num_sprites;

    // index 0 is sprite to sprite, index 1 is sprite to data
    localparam int k_m2m = 0;
    localparam int k_m2d = 1;

    logic [ns-1:0]        coll_vec;
    logic                 multi;
    logic [ns-1:0]        visible;
    logic                 border_q;
    logic                 border_rise;
    logic                 m2d_ok;

    logic [1:0][ns-1:0]   hit;
    logic [1:0]           reg_clr;
    logic [1:0]           irq_clr;

    // pending bits collect during the whole phi cycle
    logic [1:0][ns-1:0]   pend_q;
    // bits the cpu sees, refreshed while phi is low
    logic [1:0][ns-1:0]   vis_q;
    // set on the first hit after a register clear
    logic [1:0]           trig_q;
    logic [1:0]           irq_pend_q;
    logic [1:0]           irq_q;

    // hires and multicolor sprites both collide on bit 1
    always_comb begin
        for (int n = 0; n < ns; n++) begin
            coll_vec[n] = pixel_i[n][1];
        end
    end

    // two or more bits set when clearing the lowest one leaves something
    assign multi = (coll_vec & (coll_vec - 1'b1)) != '0;

    // multicolor pixels are visible in any nonzero color
    always_comb begin
        for (int n = 0; n < ns; n++) begin
            visible[n] = mmc_i[n] ? (pixel_i[n] != '0) : pixel_i[n][1];
        end
    end

    // the pixel where the border switches on still counts for m2d
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            border_q <= 1'b0;
        end else begin
            border_q <= main_border_i;
        end
    end

    assign border_rise = main_border_i && !border_q;

    // foreground test happens on the sprite stage of the sequencer
    assign m2d_ok = stage_i && !is_background_pixel_i && (!main_border_i || border_rise);

    assign hit[k_m2m] = multi ? coll_vec : '0;
    assign hit[k_m2d] = m2d_ok ? visible : '0;

    assign reg_clr[k_m2m] = coll_clr_i.m2m_clr;
    assign reg_clr[k_m2d] = coll_clr_i.m2d_clr;
    assign irq_clr[k_m2m] = coll_clr_i.immc_clr;
    assign irq_clr[k_m2d] = coll_clr_i.imbc_clr;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pend_q     <= '0;
            vis_q      <= '0;
            trig_q     <= '0;
            irq_pend_q <= '0;
            irq_q      <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                // a register clear beats any hit on the same clock
                if (reg_clr[k]) begin
                    pend_q[k] <= '0;
                    vis_q[k]  <= '0;
                    trig_q[k] <= 1'b0;
                end else begin
                    if (hit[k] != '0) begin
                        pend_q[k] <= pend_q[k] | hit[k];
                        trig_q[k] <= 1'b1;
                    end
                    // deferral, high-phase hits show up in the next low phase
                    if (!clk_phi_i) begin
                        vis_q[k] <= pend_q[k];
                    end
                end
                // interrupt flag only on the first hit since the last clear
                if (irq_clr[k]) begin
                    irq_pend_q[k] <= 1'b0;
                    irq_q[k]      <= 1'b0;
                end else begin
                    if ((hit[k] != '0) && !trig_q[k] && !reg_clr[k]) begin
                        irq_pend_q[k] <= 1'b1;
                    end
                    if (!clk_phi_i) begin
                        irq_q[k] <= irq_pend_q[k];
                    end
                end
            end
        end
    end

    assign coll_flags_o.m2m  = vis_q[k_m2m];
    assign coll_flags_o.m2d  = vis_q[k_m2d];
    assign coll_flags_o.immc = irq_q[k_m2m];
    assign coll_flags_o.imbc = irq_q[k_m2d];

endmodule

// ==== rtl/sprite_shifter.sv ====
`timescale 1ns/1ns

module sprite_shifter #(
    parameter int pixel_delay = 6
) (
    input  logic                                clk_dot4x,
    input  logic                                rst,
    input  logic                                dot_rising_0_i,
    input  sprite_pkg::sprite_cfg_t             cfg_i,
    input  logic [sprite_pkg::sprite_x_w-1:0]   xpos_i,
    input  logic                                load_i,
    input  logic [7:0]                          load_byte_i,
    output sprite_pkg::pixel_t                  pixel_o
);

    localparam int top = sprite_pkg::shift_w - 1;

    // sprite data register, msb leaves first
    logic [sprite_pkg::shift_w-1:0] shift_q;
    logic [sprite_pkg::shift_w-1:0] shift_next;
    logic                           active_q;

    // pacing flip-flops, high means hold the current value one more dot
    logic                           xe_ff_q;
    logic                           mmc_ff_q;

    // undelayed pixel and the delay line behind it
    sprite_pkg::pixel_t             cur_q;
    sprite_pkg::pixel_t             dly_q [pixel_delay];

    logic                           start;
    logic                           running;
    logic                           xe_phase;
    logic                           mmc_phase;
    logic                           has_data;
    sprite_pkg::pixel_t             next_pixel;

    // shifting begins at the dot where the beam reaches the sprite x
    assign start = !active_q && cfg_i.dma && (cfg_i.x == xpos_i);

    // a starting sprite already emits its leading pixel on this dot
    assign running = active_q || start;

    // start clears both pacing phases
    assign xe_phase  = start ? 1'b0 : xe_ff_q;
    assign mmc_phase = start ? 1'b0 : mmc_ff_q;

    // sprite stays alive while anything is left to show
    assign has_data = (shift_q != '0) || (cur_q != '0);

    // multicolor takes a bit pair, hires puts the bit in the high position
    assign next_pixel = cfg_i.mmc ? shift_q[top -: 2] : {shift_q[top], 1'b0};

    assign shift_next = {shift_q[top-1:0], 1'b0};

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_q  <= '0;
            active_q <= 1'b0;
            xe_ff_q  <= 1'b0;
            mmc_ff_q <= 1'b0;
            cur_q    <= '0;
        end else begin
            if (dot_rising_0_i && running) begin
                if (has_data) begin
                    active_q <= 1'b1;
                    // x expansion holds everything for a second dot
                    if (!xe_phase) begin
                        // multicolor updates the pixel on every other shift
                        if (!mmc_phase) begin
                            cur_q <= next_pixel;
                        end
                        shift_q  <= shift_next;
                        mmc_ff_q <= !mmc_phase && cfg_i.mmc;
                    end
                    xe_ff_q <= !xe_phase && cfg_i.xe;
                end else begin
                    // register drained and last pixel gone
                    active_q <= 1'b0;
                end
            end
            // an s-access byte is appended at the low end
            // when it lands on a dot the load wins over the shift
            if (load_i) begin
                shift_q <= {shift_q[top-8:0], load_byte_i};
            end
        end
    end

    // fixed delay so sprite pixels line up with the pixel sequencer
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < pixel_delay; i++) begin
                dly_q[i] <= '0;
            end
        end else if (dot_rising_0_i) begin
            dly_q[0] <= cur_q;
            for (int i = 1; i < pixel_delay; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign pixel_o = dly_q[pixel_delay-1];

endmodule

// ==== rtl/sprite_fetch.sv ====
`timescale 1ns/1ns

module sprite_fetch (
    input  logic                                clk_dot4x,
    input  logic                                rst,
    input  logic                                phi_phase_start_dav_i,
    input  sprite_pkg::vic_cycle_e              cycle_type_i,
    input  logic [2:0]                          sprite_cnt_i,
    input  logic [sprite_pkg::num_sprites-1:0]  dma_i,
    input  logic [11:0]                         dbi_i,
    input  logic                                aec_i,
    output sprite_pkg::fetch_t                  fetch_o
);

    logic                               s_access;
    logic                               do_load;
    logic [sprite_pkg::num_sprites-1:0] load_onehot;
    logic [7:0]                         fetch_byte;

    // s-access cycles are the only ones that carry sprite bytes
    always_comb begin
        case (cycle_type_i)
            sprite_pkg::vic_hs1,
            sprite_pkg::vic_ls2,
            sprite_pkg::vic_hs3: s_access = 1'b1;
            default:             s_access = 1'b0;
        endcase
    end

    // only a sprite with dma running takes the byte
    assign do_load = phi_phase_start_dav_i && s_access && dma_i[sprite_cnt_i];

    // one bit per sprite, selected by the sprite counter
    assign load_onehot = sprite_pkg::num_sprites'(1) << sprite_cnt_i;

    // with aec high the cpu owns the bus, so ones are shifted in
    assign fetch_byte = aec_i ? 8'hff : dbi_i[7:0];

    // load strobe is a single clock, one clock after dav
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            fetch_o.load <= '0;
        end else begin
            fetch_o.load <= do_load ? load_onehot : '0;
        end
    end

    // byte is sampled at each dav strobe
    // shifters only look at it while their load bit is high
    always_ff @(posedge clk_dot4x) begin
        if (phi_phase_start_dav_i) begin
            fetch_o.data <= fetch_byte;
        end
    end

endmodule

// ==== rtl/sprite_pkg.sv ====
package sprite_pkg;

    // eight hardware sprites
    localparam int num_sprites = 8;

    // beam x position and sprite x register share this width
    localparam int sprite_x_w = 9;

    // three sprite bytes per line
    localparam int shift_w = 24;

    // sprite pixel, zero means transparent
    // in hires mode only bit 1 carries the pixel
    typedef logic [1:0] pixel_t;

    // bus cycle types seen by the sprite logic
    // only the three s-access types load sprite data
    typedef enum logic [3:0] {
        vic_idle    = 4'd0,
        vic_refresh = 4'd1,
        vic_char    = 4'd2,
        vic_hs1     = 4'd3,
        vic_ls2     = 4'd4,
        vic_hs3     = 4'd5
    } vic_cycle_e;

    // register settings of one sprite
    // dma doubles as the display enable
    typedef struct packed {
        logic [sprite_x_w-1:0] x;
        logic                  xe;
        logic                  mmc;
        logic                  dma;
    } sprite_cfg_t;

    // one s-access result, one-hot load strobe plus the byte
    typedef struct packed {
        logic [num_sprites-1:0] load;
        logic [7:0]             data;
    } fetch_t;

    // register-side clear strobes
    typedef struct packed {
        logic m2m_clr;
        logic m2d_clr;
        logic immc_clr;
        logic imbc_clr;
    } coll_clr_t;

    // visible collision registers and interrupt flags
    typedef struct packed {
        logic [num_sprites-1:0] m2m;
        logic [num_sprites-1:0] m2d;
        logic                   immc;
        logic                   imbc;
    } coll_flags_t;

endpackage
